// File: accelCfgPkg.sv
package accelCfgPkg;

    // Vector width of the datapath, one bank lane per element
    localparam int laneCount = 4;
    localparam int laneIdxW  = 2;

    // Largest data or filter matrix, in elements
    localparam int maxElems  = 256;

    // Element count or index, wide enough to hold maxElems itself
    typedef logic [8:0] cntT;

    // Signed matrix element
    typedef logic signed [15:0] elemT;

    // Accumulator and result, wraps on overflow
    typedef logic signed [31:0] accT;

    // Word address inside one lane bank
    typedef logic [5:0] bankAddrT;

    // One bit per lane
    typedef logic [laneCount-1:0] laneMaskT;

    // Lane rotation amount
    typedef logic [laneIdxW-1:0] laneIdxT;

    typedef enum logic {IDLE, CALC} seqStateT;

endpackage

// File: accelIfs.sv
`timescale 1ns/1ps

// One-cycle write strobe from the bus mapper to every lane
interface bankWriteIf;
    import accelCfgPkg::*;
    import busMapPkg::*;

    bankAddrT wrAddr;
    logic     wrBankSel;
    laneStrbT wrStrb [laneCount];
    elemT     wrData [laneCount];

    modport write (output wrAddr, wrBankSel, wrStrb, wrData);
    modport lane  (input  wrAddr, wrBankSel, wrStrb, wrData);
endinterface

// Rotated read requests from the address generator
interface laneReadIf;
    import accelCfgPkg::*;

    bankAddrT dataAddr [laneCount];
    bankAddrT filtAddr [laneCount];
    laneMaskT dataEn;
    laneMaskT filtEn;
    laneIdxT  dataShift;
    laneIdxT  filtShift;
    logic     last;

    modport source (output dataAddr, filtAddr, dataEn, filtEn, dataShift, filtShift, last);
    modport lane   (input  dataAddr, filtAddr, dataEn, filtEn);
    modport sink   (input  dataEn, filtEn, dataShift, filtShift, last);
endinterface

// File: bankAddrGen.sv
`timescale 1ns/1ps

module bankAddrGen (
    input  logic                  clkIn,
    input  logic                  rstIn,
    input  logic                  reqValid,
    input  accelCfgPkg::cntT      filtColBeat,
    input  accelCfgPkg::cntT      filtRow,
    input  accelCfgPkg::cntT      dataCol,
    input  accelCfgPkg::cntT      dataRow,
    input  logic                  lastBeat,
    input  accelCfgPkg::laneMaskT lastMask,
    input  accelCfgPkg::cntT      filtCols,
    input  accelCfgPkg::cntT      dataCols,
    laneReadIf.source             rd
);
    import accelCfgPkg::*;

    cntT      dataLin;
    cntT      filtLin;
    laneMaskT mask1;
    logic     last1;
    logic     valid1;

    // Bank word of the vector element that lands in this lane
    function automatic bankAddrT laneWord(cntT base, int lane);
        cntT elem;
        elem = base + cntT'(laneIdxT'(lane - int'(base[laneIdxW-1:0])));
        return elem[laneIdxW +: $bits(bankAddrT)];
    endfunction

    // Element j moves to lane (j + s) mod laneCount
    function automatic laneMaskT rotMask(laneMaskT m, laneIdxT s);
        logic [2*laneCount-1:0] dbl;
        dbl = {m, m} << s;
        return dbl[2*laneCount-1 -: laneCount];
    endfunction

    // Stage one, linear element addresses
    always_ff @(posedge clkIn) begin
        dataLin <= (dataRow + filtRow) * dataCols + dataCol + (filtColBeat << laneIdxW);
        filtLin <= filtRow * filtCols + (filtColBeat << laneIdxW);
        mask1   <= lastMask;
        last1   <= lastBeat;
    end

    // Stage two, per-lane words and shifts
    always_ff @(posedge clkIn) begin
        for (int l = 0; l < laneCount; l++) begin
            rd.dataAddr[l] <= laneWord(dataLin, l);
            rd.filtAddr[l] <= laneWord(filtLin, l);
        end
        rd.dataShift <= dataLin[laneIdxW-1:0];
        rd.filtShift <= filtLin[laneIdxW-1:0];
        rd.last      <= last1;
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            valid1    <= 1'b0;
            rd.dataEn <= '0;
            rd.filtEn <= '0;
        end else begin
            valid1    <= reqValid;
            rd.dataEn <= valid1 ? rotMask(mask1, dataLin[laneIdxW-1:0]) : '0;
            rd.filtEn <= valid1 ? rotMask(mask1, filtLin[laneIdxW-1:0]) : '0;
        end
    end

    // Every requested vector starts inside the banked matrices
    assert property (@(posedge clkIn) disable iff (rstIn)
        valid1 |-> (dataLin < cntT'(maxElems) && filtLin < cntT'(maxElems)));

endmodule

// File: bankLane.sv
`timescale 1ns/1ps

module bankLane #(
    parameter int bankDepth = 64,
    parameter int laneIdx   = 0
) (
    input  logic              clkIn,
    bankWriteIf.lane          wr,
    laneReadIf.lane           rd,
    output accelCfgPkg::elemT dataRd,
    output accelCfgPkg::elemT filtRd,
    output logic              rdValid
);
    import accelCfgPkg::*;
    import busMapPkg::*;

    // Bank 0 holds data, bank 1 holds the filter
    elemT mem [2][bankDepth];

    // Byte-granular writes
    always_ff @(posedge clkIn) begin
        for (int b = 0; b < $bits(laneStrbT); b++) begin
            if (wr.wrStrb[laneIdx][b]) begin
                mem[wr.wrBankSel][wr.wrAddr][8*b +: 8] <= wr.wrData[laneIdx][8*b +: 8];
            end
        end
    end

    // Registered reads, one cycle after the address
    always_ff @(posedge clkIn) begin
        if (rd.dataEn[laneIdx]) begin
            dataRd <= mem[0][rd.dataAddr[laneIdx]];
        end
        if (rd.filtEn[laneIdx]) begin
            filtRd <= mem[1][rd.filtAddr[laneIdx]];
        end
        rdValid <= rd.dataEn[laneIdx];
    end

endmodule

// File: busMapPkg.sv
package busMapPkg;

    // Byte address, write beat and byte enables of the write port
    typedef logic [31:0] busAddrT;
    typedef logic [63:0] busDataT;
    typedef logic [7:0]  busStrbT;

    // Byte enables covering one element
    typedef logic [1:0] laneStrbT;

    // Lowest word-address bit of a byte address
    localparam int beatLsb = 3;

    // Set selects the filter bank, clear the data bank
    localparam int bankSelBit = 9;

endpackage

// File: busWriteMap.sv
`timescale 1ns/1ps

module busWriteMap (
    input  logic              clkIn,
    input  logic              rstIn,
    input  busMapPkg::busAddrT addrIn,
    input  busMapPkg::busStrbT wrEnIn,
    input  busMapPkg::busDataT wrDataIn,
    bankWriteIf.write         wrBus
);
    import accelCfgPkg::*;
    import busMapPkg::*;

    localparam int elemW = $bits(elemT);
    localparam int strbW = $bits(laneStrbT);

    // Address and data slices, payload only
    always_ff @(posedge clkIn) begin
        wrBus.wrAddr    <= addrIn[beatLsb +: $bits(bankAddrT)];
        wrBus.wrBankSel <= addrIn[bankSelBit];
        for (int i = 0; i < laneCount; i++) begin
            wrBus.wrData[i] <= wrDataIn[i*elemW +: elemW];
        end
    end

    // A beat spans all lanes, so lane i takes byte enables 2i and 2i+1
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            for (int i = 0; i < laneCount; i++) begin
                wrBus.wrStrb[i] <= '0;
            end
        end else begin
            for (int i = 0; i < laneCount; i++) begin
                wrBus.wrStrb[i] <= wrEnIn[i*strbW +: strbW];
            end
        end
    end

endmodule

// File: convAccelTb.sv
`timescale 1ns/1ps

module convAccelTb;
    import accelCfgPkg::*;
    import busMapPkg::*;

    localparam int totalResults    = 192;
    localparam int beatsPerResult  = 4;
    // readyIn is high about half the time under back-pressure
    localparam int readyDutyFactor = 2;
    localparam int runCount        = 7;
    // Loads, start pulse, pipeline fill and the quiet window of one run
    localparam int setupCycles     = 100;
    localparam int timeoutCycles   =
        totalResults * beatsPerResult * readyDutyFactor + runCount * setupCycles;
    localparam int quietCycles     = 16;

    logic    clkIn = 1'b0;
    logic    rstIn;
    logic    startIn;
    cntT     filtRowsIn;
    cntT     filtColsIn;
    cntT     dataRowsIn;
    cntT     dataColsIn;
    busAddrT addrIn;
    busStrbT wrEnIn;
    busDataT wrDataIn;
    logic    readyIn = 1'b0;
    logic    validOut;
    accT     dataOut;

    logic [15:0] lfsrState = 16'd49341;
    bit          pressureOn;
    int          cycleCount = 0;
    int          failCount = 0;
    int          resultCount;
    // Reference copy of both matrices, index 0 data, index 1 filter
    elemT        model [2][maxElems];
    accT         expQ [$];

    convAccelTop dut (
        .clkIn     (clkIn),
        .rstIn     (rstIn),
        .startIn   (startIn),
        .filtRowsIn(filtRowsIn),
        .filtColsIn(filtColsIn),
        .dataRowsIn(dataRowsIn),
        .dataColsIn(dataColsIn),
        .addrIn    (addrIn),
        .wrEnIn    (wrEnIn),
        .wrDataIn  (wrDataIn),
        .readyIn   (readyIn),
        .validOut  (validOut),
        .dataOut   (dataOut)
    );

    always #4 clkIn = ~clkIn;

    always @(posedge clkIn) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount == timeoutCycles) begin
            $display("Timeout: results did not arrive within %0d cycles", timeoutCycles);
            $display("test failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // Taps 16, 14, 13, 11
    function automatic logic nextBit();
        logic fb;
        fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
        lfsrState = {lfsrState[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], nextBit()};
        end
        return v;
    endfunction

    always @(posedge clkIn) begin
        if (pressureOn) begin
            readyIn <= nextBit();
        end else begin
            readyIn <= 1'b1;
        end
    end

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            failCount++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("test failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Element k sits in lane k mod 4 of bank word k div 4
    task automatic busWrite(input int bank, input int word, input busStrbT strb,
                            input busDataT data);
        @(posedge clkIn);
        addrIn   <= (busAddrT'(bank) << bankSelBit) | (busAddrT'(word) << beatLsb);
        wrEnIn   <= strb;
        wrDataIn <= data;
        for (int i = 0; i < laneCount; i++) begin
            for (int b = 0; b < 2; b++) begin
                if (strb[2*i+b]) begin
                    model[bank][laneCount*word+i][8*b +: 8] = data[16*i+8*b +: 8];
                end
            end
        end
    endtask

    task automatic endWrites();
        @(posedge clkIn);
        wrEnIn <= '0;
    endtask

    task automatic fillRandom(input int bank, input int count);
        for (int k = 0; k < count; k++) begin
            model[bank][k] = elemT'(randBits(16));
        end
    endtask

    task automatic pushMatrix(input int bank, input int count);
        busDataT beat;
        for (int w = 0; w < (count + laneCount - 1) / laneCount; w++) begin
            for (int i = 0; i < laneCount; i++) begin
                beat[16*i +: 16] = model[bank][laneCount*w+i];
            end
            busWrite(bank, w, 8'hFF, beat);
        end
        endWrites();
    endtask

    // Row-major over every valid filter position, sums wrap at 32 bits
    task automatic buildExpected(input int fr, input int fc, input int dr, input int dc);
        accT sum;
        expQ.delete();
        for (int r = 0; r <= dr - fr; r++) begin
            for (int c = 0; c <= dc - fc; c++) begin
                sum = '0;
                for (int i = 0; i < fr; i++) begin
                    for (int j = 0; j < fc; j++) begin
                        sum = sum + accT'(model[0][(r + i) * dc + c + j]) *
                                    accT'(model[1][i * fc + j]);
                    end
                end
                expQ.push_back(sum);
            end
        end
    endtask

    task automatic collectResults();
        while (resultCount < expQ.size()) begin
            @(negedge clkIn);
            if (validOut && readyIn) begin
                checkValue("dataOut", dataOut, expQ[resultCount]);
                resultCount++;
            end
        end
    endtask

    // Start again while the sequencer is busy
    task automatic pulseDuringRun();
        wait (resultCount >= 2);
        @(posedge clkIn);
        startIn <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
    endtask

    task automatic runConv(input int fr, input int fc, input int dr, input int dc,
                           input bit pressure, input bit extraStart);
        @(posedge clkIn);
        filtRowsIn <= cntT'(fr);
        filtColsIn <= cntT'(fc);
        dataRowsIn <= cntT'(dr);
        dataColsIn <= cntT'(dc);
        pressureOn <= pressure;
        @(posedge clkIn);
        startIn <= 1'b1;
        @(posedge clkIn);
        startIn <= 1'b0;
        resultCount = 0;
        fork
            collectResults();
            if (extraStart) pulseDuringRun();
        join
        // Nothing beyond the expected count may show up
        repeat (quietCycles) begin
            @(negedge clkIn);
            checkValue("validOut", 32'(validOut), 0);
        end
        @(posedge clkIn);
        pressureOn <= 1'b0;
        // readyIn draws no more LFSR bits after this edge
        @(posedge clkIn);
    endtask

    task automatic identityCase(input bit pressure);
        fillRandom(0, 32);
        for (int k = 0; k < laneCount; k++) begin
            model[1][k] = '0;
        end
        model[1][0] = elemT'(1);
        pushMatrix(0, 32);
        pushMatrix(1, 1);
        expQ.delete();
        for (int k = 0; k < 32; k++) begin
            expQ.push_back(accT'(model[0][k]));
        end
        runConv(1, 1, 4, 8, pressure, 1'b0);
    endtask

    task automatic generalCase(input bit pressure);
        fillRandom(1, 9);
        fillRandom(0, 42);
        pushMatrix(1, 9);
        pushMatrix(0, 42);
        buildExpected(3, 3, 6, 7);
        runConv(3, 3, 6, 7, pressure, 1'b0);
    endtask

    task automatic unalignedCase();
        fillRandom(1, 10);
        fillRandom(0, 45);
        pushMatrix(1, 10);
        pushMatrix(0, 45);
        buildExpected(2, 5, 5, 9);
        runConv(2, 5, 5, 9, 1'b0, 1'b0);
        // Byte-masked writes into one data word and one filter word
        busWrite(0, 3, 8'b0011_0100, {randBits(32), randBits(32)});
        busWrite(1, 1, 8'b1100_0001, {randBits(32), randBits(32)});
        endWrites();
        buildExpected(2, 5, 5, 9);
        runConv(2, 5, 5, 9, 1'b0, 1'b0);
    endtask

    task automatic reconfigCase();
        fillRandom(1, 12);
        fillRandom(0, 99);
        pushMatrix(1, 12);
        pushMatrix(0, 99);
        buildExpected(2, 6, 9, 11);
        runConv(2, 6, 9, 11, 1'b0, 1'b1);
    endtask

    initial begin
        rstIn      = 1'b1;
        startIn    = 1'b0;
        filtRowsIn = '0;
        filtColsIn = '0;
        dataRowsIn = '0;
        dataColsIn = '0;
        addrIn     = '0;
        wrEnIn     = '0;
        wrDataIn   = '0;
        pressureOn = 1'b0;
        for (int k = 0; k < maxElems; k++) begin
            model[0][k] = '0;
            model[1][k] = '0;
        end
        repeat (4) @(posedge clkIn);
        rstIn <= 1'b0;
        @(negedge clkIn);
        checkValue("validOut", 32'(validOut), 0);
        identityCase(1'b0);
        generalCase(1'b0);
        unalignedCase();
        generalCase(1'b1);
        identityCase(1'b1);
        reconfigCase();
        if (failCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// File: convAccelTop.sv
`timescale 1ns/1ps

module convAccelTop #(
    parameter int bankDepth = accelCfgPkg::maxElems / accelCfgPkg::laneCount,
    parameter int fifoDepth = 32,
    parameter int fifoSkid  = 16
) (
    input  logic               clkIn,
    input  logic               rstIn,
    input  logic               startIn,
    input  accelCfgPkg::cntT   filtRowsIn,
    input  accelCfgPkg::cntT   filtColsIn,
    input  accelCfgPkg::cntT   dataRowsIn,
    input  accelCfgPkg::cntT   dataColsIn,
    input  busMapPkg::busAddrT addrIn,
    input  busMapPkg::busStrbT wrEnIn,
    input  busMapPkg::busDataT wrDataIn,
    input  logic               readyIn,
    output logic               validOut,
    output accelCfgPkg::accT   dataOut
);
    import accelCfgPkg::*;

    bankWriteIf wrBus ();
    laneReadIf  rdBus ();

    logic     reqValid;
    cntT      filtColBeat;
    cntT      filtRow;
    cntT      dataCol;
    cntT      dataRow;
    logic     lastBeat;
    laneMaskT lastMask;
    cntT      filtCols;
    cntT      dataCols;
    logic     fifoOpen;
    elemT     laneData [laneCount];
    elemT     laneFilt [laneCount];
    laneMaskT laneValid;
    logic     resWr;
    accT      resData;

    busWriteMap uWriteMap (
        .clkIn   (clkIn),
        .rstIn   (rstIn),
        .addrIn  (addrIn),
        .wrEnIn  (wrEnIn),
        .wrDataIn(wrDataIn),
        .wrBus   (wrBus)
    );

    windowSequencer uSeq (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .startIn    (startIn),
        .filtRowsIn (filtRowsIn),
        .filtColsIn (filtColsIn),
        .dataRowsIn (dataRowsIn),
        .dataColsIn (dataColsIn),
        .fifoOpen   (fifoOpen),
        .reqValid   (reqValid),
        .filtColBeat(filtColBeat),
        .filtRow    (filtRow),
        .dataCol    (dataCol),
        .dataRow    (dataRow),
        .lastBeat   (lastBeat),
        .lastMask   (lastMask),
        .filtCols   (filtCols),
        .dataCols   (dataCols)
    );

    bankAddrGen uAddrGen (
        .clkIn      (clkIn),
        .rstIn      (rstIn),
        .reqValid   (reqValid),
        .filtColBeat(filtColBeat),
        .filtRow    (filtRow),
        .dataCol    (dataCol),
        .dataRow    (dataRow),
        .lastBeat   (lastBeat),
        .lastMask   (lastMask),
        .filtCols   (filtCols),
        .dataCols   (dataCols),
        .rd         (rdBus)
    );

    for (genvar l = 0; l < laneCount; l++) begin : gLane
        bankLane #(
            .bankDepth(bankDepth),
            .laneIdx  (l)
        ) uLane (
            .clkIn  (clkIn),
            .wr     (wrBus),
            .rd     (rdBus),
            .dataRd (laneData[l]),
            .filtRd (laneFilt[l]),
            .rdValid(laneValid[l])
        );
    end

    dotAccumulate uDot (
        .clkIn  (clkIn),
        .rstIn  (rstIn),
        .rd     (rdBus),
        .dataRd (laneData),
        .filtRd (laneFilt),
        .rdValid(laneValid),
        .resWr  (resWr),
        .resData(resData)
    );

    resultFifo #(
        .fifoDepth(fifoDepth),
        .fifoSkid (fifoSkid)
    ) uFifo (
        .clkIn   (clkIn),
        .rstIn   (rstIn),
        .resWr   (resWr),
        .resData (resData),
        .readyIn (readyIn),
        .validOut(validOut),
        .dataOut (dataOut),
        .fifoOpen(fifoOpen)
    );

endmodule

// File: dotAccumulate.sv
`timescale 1ns/1ps

module dotAccumulate (
    input  logic                  clkIn,
    input  logic                  rstIn,
    laneReadIf.sink               rd,
    input  accelCfgPkg::elemT     dataRd [accelCfgPkg::laneCount],
    input  accelCfgPkg::elemT     filtRd [accelCfgPkg::laneCount],
    input  accelCfgPkg::laneMaskT rdValid,
    output logic                  resWr,
    output accelCfgPkg::accT      resData
);
    import accelCfgPkg::*;

    // Request fields lined up with the lane read data
    laneIdxT  dataShiftD;
    laneIdxT  filtShiftD;
    laneMaskT filtEnD;
    logic     lastD;

    // Element order restored
    elemT     dataU [laneCount];
    elemT     filtU [laneCount];
    laneMaskT validU;
    logic     lastU;
    logic     beatU;

    accT      beatSum;
    accT      acc;

    always_ff @(posedge clkIn) begin
        dataShiftD <= rd.dataShift;
        filtShiftD <= rd.filtShift;
        filtEnD    <= rd.filtEn;
        lastD      <= rd.last;
    end

    always_ff @(posedge clkIn) begin
        for (int j = 0; j < laneCount; j++) begin
            dataU[j]  <= dataRd[laneIdxT'(j + int'(dataShiftD))];
            filtU[j]  <= filtRd[laneIdxT'(j + int'(filtShiftD))];
            validU[j] <= rdValid[laneIdxT'(j + int'(dataShiftD))] &&
                         filtEnD[laneIdxT'(j + int'(filtShiftD))];
        end
        lastU <= lastD;
    end

    always_comb begin
        beatSum = '0;
        for (int j = 0; j < laneCount; j++) begin
            if (validU[j]) begin
                beatSum = beatSum + accT'(dataU[j]) * accT'(filtU[j]);
            end
        end
    end

    // Emit on the last beat of a position, then start over
    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            beatU <= 1'b0;
            resWr <= 1'b0;
            acc   <= '0;
        end else begin
            beatU <= |rdValid;
            resWr <= beatU && lastU;
            if (beatU) begin
                if (lastU) begin
                    resData <= acc + beatSum;
                    acc     <= '0;
                end else begin
                    acc <= acc + beatSum;
                end
            end
        end
    end

endmodule

// File: project.f
accelCfgPkg.sv
busMapPkg.sv
accelIfs.sv
busWriteMap.sv
windowSequencer.sv
bankAddrGen.sv
bankLane.sv
dotAccumulate.sv
resultFifo.sv
convAccelTop.sv
convAccelTb.sv

// File: resultFifo.sv
`timescale 1ns/1ps

module resultFifo #(
    parameter int fifoDepth = 32,
    parameter int fifoSkid  = 16
) (
    input  logic             clkIn,
    input  logic             rstIn,
    input  logic             resWr,
    input  accelCfgPkg::accT resData,
    input  logic             readyIn,
    output logic             validOut,
    output accelCfgPkg::accT dataOut,
    output logic             fifoOpen
);
    import accelCfgPkg::*;

    localparam int ptrW = $clog2(fifoDepth);
    localparam int cntW = ptrW + 1;

    accT             mem [fifoDepth];
    logic [ptrW-1:0] wrPtr;
    logic [ptrW-1:0] rdPtr;
    logic [cntW-1:0] count;
    logic            rdFire;

    assign validOut = count != '0;
    assign dataOut  = mem[rdPtr];
    assign rdFire   = validOut && readyIn;

    // Skid room absorbs the requests still in the pipeline
    assign fifoOpen = count < cntW'(fifoDepth - fifoSkid);

    always_ff @(posedge clkIn) begin
        if (resWr) begin
            mem[wrPtr] <= resData;
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            wrPtr <= wrPtr + ptrW'(resWr);
            rdPtr <= rdPtr + ptrW'(rdFire);
            count <= count + cntW'(resWr) - cntW'(rdFire);
        end
    end

    // Upstream throttling must keep a result from arriving at a full buffer
    assert property (@(posedge clkIn) disable iff (rstIn)
        resWr |-> count < cntW'(fifoDepth));

endmodule

// File: runSim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module convAccelTb -f project.f -o convAccelSim

# The log decides the result, the simulator status is not used
./obj_dir/convAccelSim | tee sim.log

if grep -q "test failed" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// File: windowSequencer.sv
`timescale 1ns/1ps

module windowSequencer (
    input  logic                  clkIn,
    input  logic                  rstIn,
    input  logic                  startIn,
    input  accelCfgPkg::cntT      filtRowsIn,
    input  accelCfgPkg::cntT      filtColsIn,
    input  accelCfgPkg::cntT      dataRowsIn,
    input  accelCfgPkg::cntT      dataColsIn,
    input  logic                  fifoOpen,
    output logic                  reqValid,
    output accelCfgPkg::cntT      filtColBeat,
    output accelCfgPkg::cntT      filtRow,
    output accelCfgPkg::cntT      dataCol,
    output accelCfgPkg::cntT      dataRow,
    output logic                  lastBeat,
    output accelCfgPkg::laneMaskT lastMask,
    output accelCfgPkg::cntT      filtCols,
    output accelCfgPkg::cntT      dataCols
);
    import accelCfgPkg::*;

    seqStateT state;
    cntT      filtColsM1;
    cntT      beatEnd;
    cntT      filtRowEnd;
    cntT      dataColEnd;
    cntT      dataRowEnd;
    laneIdxT  lastLane;
    logic     beatDone;
    logic     rowDone;
    logic     colDone;
    logic     allDone;

    assign filtColsM1 = filtColsIn - cntT'(1);

    // Configuration follows the inputs until the start strobe
    always_ff @(posedge clkIn) begin
        if (state == IDLE) begin
            filtCols   <= filtColsIn;
            dataCols   <= dataColsIn;
            beatEnd    <= filtColsM1 >> laneIdxW;
            lastLane   <= filtColsM1[laneIdxW-1:0];
            filtRowEnd <= filtRowsIn - cntT'(1);
            dataColEnd <= dataColsIn - filtColsIn;
            dataRowEnd <= dataRowsIn - filtRowsIn;
        end
    end

    // FIFO level throttles every request
    assign reqValid = (state == CALC) && fifoOpen;
    assign beatDone = filtColBeat == beatEnd;
    assign rowDone  = filtRow == filtRowEnd;
    assign colDone  = dataCol == dataColEnd;
    assign lastBeat = beatDone && rowDone;
    assign allDone  = lastBeat && colDone && (dataRow == dataRowEnd);

    // Partial mask only on the final filter-column beat
    always_comb begin
        for (int j = 0; j < laneCount; j++) begin
            lastMask[j] = !beatDone || (laneIdxT'(j) <= lastLane);
        end
    end

    always_ff @(posedge clkIn) begin
        if (rstIn) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (startIn) state <= CALC;
                CALC: if (reqValid && allDone) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Nested counters, innermost is the filter column beat
    always_ff @(posedge clkIn) begin
        if (rstIn || state == IDLE) begin
            filtColBeat <= '0;
            filtRow     <= '0;
            dataCol     <= '0;
            dataRow     <= '0;
        end else if (reqValid) begin
            filtColBeat <= beatDone ? '0 : filtColBeat + cntT'(1);
            if (beatDone) begin
                filtRow <= rowDone ? '0 : filtRow + cntT'(1);
                if (rowDone) begin
                    dataCol <= colDone ? '0 : dataCol + cntT'(1);
                    if (colDone) begin
                        dataRow <= dataRow + cntT'(1);
                    end
                end
            end
        end
    end

    // A start needs a filter that fits inside the data matrix
    assert property (@(posedge clkIn) disable iff (rstIn)
        (state == IDLE && startIn) |->
            (filtRowsIn != '0 && filtColsIn != '0 &&
             filtRowsIn <= dataRowsIn && filtColsIn <= dataColsIn));

endmodule
